// File: verilog/accel_defs.svh
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// number of peer accumulator cores
`define ACC_NUM_CORES 4

// word width on the bus and on the stream
`define ACC_DATA_W 32

// result ram address, one slot per core
`define ACC_ADDR_W 2

// base loop length, core k runs this plus k
`define ACC_ITERS 8

`endif

// File: verilog/accel_types_pkg.sv
`default_nettype none

`include "accel_defs.svh"

package accel_types_pkg;

    // operand and result word
    typedef logic [`ACC_DATA_W-1:0] data_t;
    // result ram address
    typedef logic [`ACC_ADDR_W-1:0] addr_t;
    // core index, same width as the ram address
    typedef logic [`ACC_ADDR_W-1:0] core_id_t;
    // one bit per core, done flags and grants
    typedef logic [`ACC_NUM_CORES-1:0] core_mask_t;

endpackage

`default_nettype wire

// File: verilog/accel_ctrl_pkg.sv
`default_nettype none

package accel_ctrl_pkg;

    // per core sequencing
    typedef enum logic [1:0] {IDLE, RUN, WRITE, DONE} core_state_t;

    // bus arbiter
    typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

endpackage

`default_nettype wire

// File: verilog/wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

// wishbone classic, write only in this design
interface wb_bus_if import accel_types_pkg::*; ();

    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat_w;
    logic  ack;

    modport master (output cyc, stb, we, adr, dat_w, input ack);
    modport slave (input cyc, stb, we, adr, dat_w, output ack);

endinterface

`default_nettype wire

// File: verilog/agu.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

// address counter, 0 up to fin then sticks there
module agu #(
    parameter int W = `ACC_ADDR_W
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic         start,
    input  logic [W-1:0] fin,
    output logic [W-1:0] data,
    output logic         last
);

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (en) begin
            // start wins over counting
            if (start) begin
                data <= '0;
            end else if (data != fin) begin
                data <= data + 1'b1;
            end
        end
    end

    // high for as long as the counter sits at fin
    assign last = (data == fin);

endmodule

`default_nettype wire

// File: verilog/accum_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module accum_core import accel_types_pkg::*; import accel_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  core_id_t core_id,
    input  logic     start,
    input  data_t    operand,
    wb_bus_if.master bus,
    output logic     done
);

    core_state_t state;
    data_t       op_q;
    data_t       acc;
    data_t       add_val;
    logic [7:0]  iter_cnt;
    logic        last_iter;

    // first ACC_ITERS cycles add op+id and the id extra cycles add nothing
    assign add_val   = (iter_cnt < 8'(`ACC_ITERS)) ? op_q + data_t'(core_id) : '0;
    assign last_iter = (iter_cnt == 8'(`ACC_ITERS + core_id - 1));

    // ========================================================================
    // sequencing
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                // start while busy falls through untouched
                IDLE:    if (start) state <= RUN;
                RUN:     if (last_iter) state <= WRITE;
                WRITE:   if (bus.ack) state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // operand capture and accumulate
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            op_q     <= operand;
            acc      <= '0;
            iter_cnt <= '0;
        end else if (state == RUN) begin
            acc      <= acc + add_val;
            iter_cnt <= iter_cnt + 8'd1;
        end
    end

    // bus request lives exactly as long as WRITE
    assign bus.cyc   = (state == WRITE);
    assign bus.stb   = (state == WRITE);
    assign bus.we    = (state == WRITE);
    assign bus.adr   = addr_t'(core_id);
    assign bus.dat_w = acc;

    // one cycle after the ack
    assign done = (state == DONE);

    // request and its payload hold until the slave answers
    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        (bus.stb && !bus.ack) |=> (bus.stb && $stable(bus.dat_w) && $stable(bus.adr)));

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module wb_arbiter import accel_types_pkg::*; import accel_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    wb_bus_if.slave  masters [`ACC_NUM_CORES],
    wb_bus_if.master slave
);

    arb_state_t state;
    core_mask_t req;
    core_mask_t grant;
    core_mask_t pick_mask;
    core_id_t   last_id;
    core_id_t   pick_id;
    logic       stb_v [`ACC_NUM_CORES];
    logic       we_v  [`ACC_NUM_CORES];
    addr_t      adr_v [`ACC_NUM_CORES];
    data_t      dat_v [`ACC_NUM_CORES];

    // flatten the interface array, ack only to the granted core
    genvar k;
    generate
        for (k = 0; k < `ACC_NUM_CORES; k++) begin : g_port
            assign req[k]         = masters[k].cyc;
            assign stb_v[k]       = masters[k].stb;
            assign we_v[k]        = masters[k].we;
            assign adr_v[k]       = masters[k].adr;
            assign dat_v[k]       = masters[k].dat_w;
            assign masters[k].ack = slave.ack & grant[k];
        end
    endgenerate

    // ========================================================================
    // round robin, search starts one past the last winner
    // ========================================================================
    always_comb begin
        core_id_t cand;
        pick_id = last_id;
        // walk down so last_id+1 is the final override, highest priority
        for (int i = `ACC_NUM_CORES; i >= 1; i--) begin
            cand = core_id_t'(last_id + i);
            if (req[cand]) pick_id = cand;
        end
        pick_mask = core_mask_t'(1) << pick_id;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ARB_IDLE;
            grant   <= '0;
            last_id <= core_id_t'(`ACC_NUM_CORES - 1);
        end else begin
            case (state)
                ARB_IDLE: if (|req) begin
                    grant   <= pick_mask;
                    last_id <= pick_id;
                    state   <= ARB_BUSY;
                end
                // owner keeps the bus until it drops cyc
                ARB_BUSY: if (!(|(req & grant))) begin
                    grant <= '0;
                    state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // route the owner to the ram
    always_comb begin
        slave.cyc   = 1'b0;
        slave.stb   = 1'b0;
        slave.we    = 1'b0;
        slave.adr   = '0;
        slave.dat_w = '0;
        for (int i = 0; i < `ACC_NUM_CORES; i++) begin
            if (grant[i]) begin
                slave.cyc   = req[i];
                slave.stb   = stb_v[i];
                slave.we    = we_v[i];
                slave.adr   = adr_v[i];
                slave.dat_w = dat_v[i];
            end
        end
    end

    // single owner, and only while busy
    a_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant != '0) == (state == ARB_BUSY)));

endmodule

`default_nettype wire

// File: verilog/result_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module result_ram import accel_types_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    wb_bus_if.slave bus,
    input  logic    rd_en,
    input  addr_t   rd_addr,
    output data_t   rd_data
);

    data_t mem [`ACC_NUM_CORES];
    logic  wr_go;

    // accept on the first cycle of a strobe, ack goes out alongside
    assign wr_go = bus.cyc & bus.stb & bus.we & ~bus.ack;

    // ack one cycle after stb, single cycle wide
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc & bus.stb & ~bus.ack;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) mem[bus.adr] <= bus.dat_w;
    end

    // stream side read, holds when rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: verilog/stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module stream_ctrl import accel_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  core_mask_t done,
    input  logic       dst_ready,
    output logic       dst_valid,
    output logic       dst_last,
    output logic       stream_v,
    output addr_t      rd_addr
);

    core_mask_t done_seen;
    logic       all_seen;
    logic       all_done_n;
    logic       done_keep;
    logic       stream_ok;
    logic       stream_active;
    logic       agu_start;
    logic       last_addr;

    // ========================================================================
    // done collection
    // ========================================================================
    assign all_seen = &done_seen;

    // sticky per core, cleared once the full set is in
    always_ff @(posedge clk) begin
        if (rst) begin
            done_seen <= '0;
        end else if (all_seen) begin
            done_seen <= '0;
        end else begin
            done_seen <= done_seen | done;
        end
    end

    // registered detect, single pulse
    always_ff @(posedge clk) begin
        if (rst) all_done_n <= 1'b0;
        else     all_done_n <= all_seen;
    end

    // remember the pulse if the sink is stalled or a stream still runs
    always_ff @(posedge clk) begin
        if (rst) begin
            done_keep <= 1'b0;
        end else if (stream_ok) begin
            done_keep <= 1'b0;
        end else if (all_done_n) begin
            done_keep <= 1'b1;
        end
    end

    assign stream_ok = (all_done_n | done_keep) & dst_ready & ~stream_active;
    assign agu_start = stream_ok;

    // ========================================================================
    // streaming, everything moves only with dst_ready
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (stream_ok) begin
            stream_active <= 1'b1;
        end else if (dst_ready & last_addr) begin
            stream_active <= 1'b0;
        end
    end

    agu #(.W(`ACC_ADDR_W)) u_agu (
        .clk   (clk),
        .rst   (rst),
        .en    (dst_ready),
        .start (agu_start),
        .fin   (addr_t'(`ACC_NUM_CORES - 1)),
        .data  (rd_addr),
        .last  (last_addr)
    );

    // ram read one cycle ahead of valid
    assign stream_v = stream_active & dst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_addr;
        end
    end

    a_last_valid: assert property (@(posedge clk) disable iff (rst)
        dst_last |-> dst_valid);

endmodule

`default_nettype wire

// File: verilog/accel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module accel_top import accel_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  data_t operand,
    input  logic  dst_ready,
    output logic  dst_valid,
    output logic  dst_last,
    output data_t dst_data
);

    core_mask_t done;
    logic       stream_v;
    addr_t      rd_addr;

    // one bus per core, one toward the ram
    wb_bus_if core_bus [`ACC_NUM_CORES] ();
    wb_bus_if ram_bus ();

    // ========================================================================
    // cores, operand broadcast to all
    // ========================================================================
    genvar k;
    generate
        for (k = 0; k < `ACC_NUM_CORES; k++) begin : g_core
            accum_core u_core (
                .clk     (clk),
                .rst     (rst),
                .core_id (core_id_t'(k)),
                .start   (start),
                .operand (operand),
                .bus     (core_bus[k]),
                .done    (done[k])
            );
        end
    endgenerate

    wb_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .masters (core_bus),
        .slave   (ram_bus)
    );

    // registered read data is the stream payload
    result_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .bus     (ram_bus),
        .rd_en   (stream_v),
        .rd_addr (rd_addr),
        .rd_data (dst_data)
    );

    stream_ctrl u_stream (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .stream_v  (stream_v),
        .rd_addr   (rd_addr)
    );

endmodule

`default_nettype wire

// File: testbench/tb_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module tb_accel_top import accel_types_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_CYC   = 5;
    localparam int NUM_RUNS    = 20;
    localparam int IDLE_CYC    = 6;
    // 200 cycles per run plus reset and the idle phase
    localparam int WATCHDOG_NS = (NUM_RUNS * 200 + RESET_CYC + IDLE_CYC) * CLK_PERIOD;

    logic  clk = 1'b0;
    logic  rst;
    logic  start;
    data_t operand;
    logic  dst_ready;
    logic  dst_valid;
    logic  dst_last;
    data_t dst_data;

    // expected words of the current run in address order
    data_t       exp_word [`ACC_NUM_CORES];
    int          xfer_cnt;
    logic        ready_q;
    logic        prev_valid;
    logic        prev_last;
    data_t       prev_data;
    data_t       run_op;

    always #(CLK_PERIOD / 2) clk = ~clk;

    accel_top UUT (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .operand   (operand),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_data  (dst_data)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // core k adds op+k for ACC_ITERS cycles and wraps at 32 bits
    function automatic data_t model_word(input data_t op, input int k);
        return data_t'(`ACC_ITERS * (op + data_t'(k)));
    endfunction

    // =========================================================================
    // per word check on a cycle with valid and ready high
    // =========================================================================
    task automatic check_word();
        addr_t idx;
        logic  exp_last;
        assert (xfer_cnt < `ACC_NUM_CORES)
            else stop_on_error("a word was transferred outside of a stream");
        idx      = addr_t'(xfer_cnt);
        exp_last = (xfer_cnt == `ACC_NUM_CORES - 1);
        assert (dst_data === exp_word[idx])
            else stop_on_error($sformatf("Mismatch dst_data word %0d: got %h expected %h",
                                         xfer_cnt, dst_data, exp_word[idx]));
        assert (dst_last === exp_last)
            else stop_on_error($sformatf("Mismatch dst_last word %0d: got %h expected %h",
                                         xfer_cnt, dst_last, exp_last));
        xfer_cnt++;
    endtask

    // sample just after the edge and then drive the next cycle
    task automatic tick(input logic start_v, input data_t op_v);
        @(posedge clk);
        #1;
        // sink stalled last cycle so outputs stay frozen
        if (!ready_q) begin
            assert (dst_valid === prev_valid)
                else stop_on_error($sformatf("Mismatch dst_valid in stall: got %h expected %h",
                                             dst_valid, prev_valid));
            assert (dst_last === prev_last)
                else stop_on_error($sformatf("Mismatch dst_last in stall: got %h expected %h",
                                             dst_last, prev_last));
            assert (dst_data === prev_data)
                else stop_on_error($sformatf("Mismatch dst_data in stall: got %h expected %h",
                                             dst_data, prev_data));
        end
        prev_valid = dst_valid;
        prev_last  = dst_last;
        prev_data  = dst_data;
        start      = start_v;
        operand    = op_v;
        // ready high about 70 percent of cycles
        dst_ready  = (($urandom % 10) < 7);
        ready_q    = dst_ready;
        if (dst_valid && dst_ready) check_word();
    endtask

    // =========================================================================
    // main sequence
    // =========================================================================
    initial begin
        void'($urandom(32'h97d8));
        rst        = 1'b1;
        start      = 1'b0;
        operand    = '0;
        dst_ready  = 1'b0;
        ready_q    = 1'b1;
        prev_valid = 1'b0;
        prev_last  = 1'b0;
        prev_data  = '0;
        // no stream open yet so any word counts as extra
        xfer_cnt   = `ACC_NUM_CORES;
        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet output before the first start
        repeat (IDLE_CYC) begin
            tick(1'b0, data_t'($urandom));
            assert (!dst_valid && !dst_last)
                else stop_on_error("dst_valid or dst_last went high before any start");
        end

        for (int run = 0; run < NUM_RUNS; run++) begin
            // zero and all ones first for wraparound
            if (run == 0) begin
                run_op = '0;
            end else if (run == 1) begin
                run_op = '1;
            end else begin
                run_op = data_t'($urandom);
            end
            for (int k = 0; k < `ACC_NUM_CORES; k++) begin
                exp_word[k] = model_word(run_op, k);
            end
            tick(1'b1, run_op);
            // open the new stream only after the start cycle
            xfer_cnt = 0;
            while (xfer_cnt < `ACC_NUM_CORES) begin
                tick(1'b0, data_t'($urandom));
            end
        end

        // nothing may follow the final last word
        tick(1'b0, data_t'($urandom));
        assert (!dst_valid)
            else stop_on_error("dst_valid still high after the final word of the last run");
        $display("Test completed successfully");
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before all runs finished streaming");
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/accel_types_pkg.sv
verilog/accel_ctrl_pkg.sv
verilog/wb_bus_if.sv
verilog/agu.sv
verilog/accum_core.sv
verilog/wb_arbiter.sv
verilog/result_ram.sv
verilog/stream_ctrl.sv
verilog/accel_top.sv
testbench/tb_accel_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_accel_top -f filelist.f -o tb_accel_top \
    && ./obj_dir/tb_accel_top \
    || exit 1
